// File: include/nmea_defs.svh
`ifndef NMEA_DEFS_SVH
`define NMEA_DEFS_SVH

// System clock of 125 MHz
`define NMEA_CLK_FREQ 125_000_000

// Fast serial rate so that each bit lasts 16 clocks
`define NMEA_BAUD_RATE 7_812_500
`define NMEA_CLKS_PER_BIT (`NMEA_CLK_FREQ / `NMEA_BAUD_RATE)

// Equal PPS samples required before the filtered level follows
`define NMEA_PPS_DEBOUNCE 5

`define NMEA_HEADER "GPZDA,"
`define NMEA_HEADER_LEN 6

`endif

// File: logic/uart_pkg.sv
package uart_pkg;

    // One received character on a valid-only stream
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } byte_beat_t;

endpackage

// File: logic/nmea_pkg.sv
package nmea_pkg;

    // Binary time of day as kept by the time keeper
    typedef struct packed {
        logic [4:0] hour;
        logic [5:0] minute;
        logic [5:0] second;
    } time_of_day_t;

    // One decoded two-digit field of the ZDA sentence
    typedef struct packed {
        logic [6:0] value;
        logic [1:0] index;  // 0 hour, 1 minute, 2 second
        logic       valid;
    } field_beat_t;

endpackage

// File: logic/uart_rx.sv
`timescale 1ns/1ns
`include "nmea_defs.svh"

module uart_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    output uart_pkg::byte_beat_t rx_beat
);
    localparam int CPB   = `NMEA_CLKS_PER_BIT;
    localparam int CNT_W = $clog2(CPB + 1);
    localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CPB / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CPB - 1);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    logic [1:0]       sync_q;
    logic             rx_s;
    state_t           state;
    logic [CNT_W-1:0] bit_cnt;   // Clock cycles within the current bit
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    assign rx_s = sync_q[1];

    // Line idles high, so the synchronizer starts there too
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], rx};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            bit_cnt       <= '0;
            bit_idx       <= '0;
            rx_beat.valid <= 1'b0;
        end else begin
            rx_beat.valid <= 1'b0;
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    if (!rx_s) state <= START;
                end
                START: begin
                    // Half a bit later we sit in the middle of the start bit
                    if (bit_cnt == HALF_BIT) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? IDLE : DATA;  // High again means a glitch
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_cnt == FULL_BIT) begin
                        bit_cnt <= '0;
                        shift_q <= {rx_s, shift_q[7:1]};  // LSB arrives first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= STOP;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_cnt == FULL_BIT) begin
                        state <= IDLE;
                        if (rx_s) begin  // Framing error drops the byte
                            rx_beat.valid <= 1'b1;
                            rx_beat.data  <= shift_q;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    a_single_beat: assert property (@(posedge clk) disable iff (rst)
        rx_beat.valid |=> !rx_beat.valid);

endmodule

// File: logic/zda_search.sv
`timescale 1ns/1ns
`include "nmea_defs.svh"

module zda_search (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_pkg::byte_beat_t in_beat,
    output logic                 header_seen,
    output uart_pkg::byte_beat_t payload_beat
);
    localparam int HDR_LEN     = `NMEA_HEADER_LEN;
    localparam int PAYLOAD_LEN = 6;  // hhmmss
    localparam int IDX_W       = $clog2(HDR_LEN);
    localparam int CNT_W       = $clog2(PAYLOAD_LEN + 1);
    localparam logic [8*HDR_LEN-1:0] HEADER = `NMEA_HEADER;

    logic [IDX_W-1:0] match_idx;   // Header characters matched so far
    logic [CNT_W-1:0] remaining;   // Payload bytes still to forward
    logic [7:0]       expected;
    logic [7:0]       first_char;

    // The first header character sits in the top byte of the string
    assign expected   = HEADER[8*(HDR_LEN-1-int'(match_idx)) +: 8];
    assign first_char = HEADER[8*HDR_LEN-1 -: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            match_idx          <= '0;
            remaining          <= '0;
            header_seen        <= 1'b0;
            payload_beat.valid <= 1'b0;
        end else begin
            header_seen        <= 1'b0;
            payload_beat.valid <= 1'b0;
            if (in_beat.valid) begin
                if (remaining != '0) begin
                    payload_beat.valid <= 1'b1;
                    payload_beat.data  <= in_beat.data;
                    remaining          <= remaining - 1'b1;
                end else if (in_beat.data == expected) begin
                    if (match_idx == IDX_W'(HDR_LEN - 1)) begin
                        match_idx   <= '0;
                        header_seen <= 1'b1;
                        remaining   <= CNT_W'(PAYLOAD_LEN);
                    end else begin
                        match_idx <= match_idx + 1'b1;
                    end
                end else begin
                    // A broken match may still start a fresh header on this byte
                    match_idx <= (in_beat.data == first_char) ? IDX_W'(1) : '0;
                end
            end
        end
    end

endmodule

// File: logic/time_field_decoder.sv
`timescale 1ns/1ns

module time_field_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  new_sentence,
    input  uart_pkg::byte_beat_t  digit_beat,
    output nmea_pkg::field_beat_t field_beat
);
    logic       have_tens;  // Tens digit of the current pair is stored
    logic [3:0] tens_q;
    logic [3:0] units;
    logic [1:0] field_idx;

    // ASCII digits carry their value in the low nibble
    assign units = digit_beat.data[3:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            have_tens        <= 1'b0;
            field_idx        <= '0;
            field_beat.valid <= 1'b0;
        end else begin
            field_beat.valid <= 1'b0;
            if (new_sentence) begin
                have_tens <= 1'b0;
                field_idx <= '0;
            end else if (digit_beat.valid) begin
                if (!have_tens) begin
                    tens_q    <= units;
                    have_tens <= 1'b1;
                end else begin
                    have_tens        <= 1'b0;
                    field_beat.valid <= 1'b1;
                    field_beat.value <= 7'(tens_q) * 7'd10 + 7'(units);
                    field_beat.index <= field_idx;
                    field_idx        <= (field_idx == 2'd2) ? 2'd0 : field_idx + 2'd1;
                end
            end
        end
    end

endmodule

// File: logic/time_keeper.sv
`timescale 1ns/1ns
`include "nmea_defs.svh"

module time_keeper (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pps_in,
    input  nmea_pkg::field_beat_t  field_beat,
    output nmea_pkg::time_of_day_t time_now,
    output logic                   time_valid,
    output logic                   pps_tick,
    output logic [31:0]            subsec
);
    localparam int DEB = `NMEA_PPS_DEBOUNCE;

    logic [DEB-1:0] pps_shift;
    logic           pps_level;    // Filtered PPS
    logic           pps_level_q;
    logic [2:0]     loaded;       // One bit per field index

    // The level only moves once every sample in the window agrees
    always_ff @(posedge clk) begin
        if (rst) begin
            pps_shift   <= '0;
            pps_level   <= 1'b0;
            pps_level_q <= 1'b0;
            pps_tick    <= 1'b0;
        end else begin
            pps_shift <= {pps_shift[DEB-2:0], pps_in};
            if (&pps_shift) pps_level <= 1'b1;
            else if (~|pps_shift) pps_level <= 1'b0;
            pps_level_q <= pps_level;
            pps_tick    <= pps_level & ~pps_level_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) subsec <= '0;
        else if (pps_tick) subsec <= '0;  // Sub-second count restarts at each second
        else subsec <= subsec + 32'd1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            time_now   <= '0;
            loaded     <= '0;
            time_valid <= 1'b0;
        end else begin
            time_valid <= &loaded;
            if (field_beat.valid) begin
                case (field_beat.index)
                    2'd0: begin
                        time_now.hour <= 5'(field_beat.value);
                        loaded[0]     <= 1'b1;
                    end
                    2'd1: begin
                        time_now.minute <= 6'(field_beat.value);
                        loaded[1]       <= 1'b1;
                    end
                    default: begin
                        time_now.second <= 6'(field_beat.value);
                        loaded[2]       <= 1'b1;
                    end
                endcase
            end else if (pps_tick && time_valid) begin
                if (time_now.second == 6'd59) begin
                    time_now.second <= '0;
                    if (time_now.minute == 6'd59) begin
                        time_now.minute <= '0;
                        time_now.hour   <= (time_now.hour == 5'd23) ? 5'd0 : time_now.hour + 5'd1;
                    end else begin
                        time_now.minute <= time_now.minute + 6'd1;
                    end
                end else begin
                    time_now.second <= time_now.second + 6'd1;
                end
            end
        end
    end

    a_time_range: assert property (@(posedge clk) disable iff (rst)
        time_valid |-> (time_now.hour < 5'd24) && (time_now.minute < 6'd60)
                       && (time_now.second < 6'd60));

endmodule

// File: logic/gnss_time_top.sv
`timescale 1ns/1ns

module gnss_time_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   uart_rx_line,
    input  logic                   pps_in,
    output logic                   header_seen,
    output nmea_pkg::time_of_day_t time_now,
    output logic                   time_valid,
    output logic [31:0]            subsec,
    output logic                   pps_tick
);
    import uart_pkg::*;
    import nmea_pkg::*;

    byte_beat_t  rx_beat;       // Every received character
    byte_beat_t  payload_beat;  // Characters after the ZDA header
    field_beat_t field_beat;

    uart_rx uart_rx_i (
        .clk     (clk),
        .rst     (rst),
        .rx      (uart_rx_line),
        .rx_beat (rx_beat)
    );

    zda_search zda_search_i (
        .clk          (clk),
        .rst          (rst),
        .in_beat      (rx_beat),
        .header_seen  (header_seen),
        .payload_beat (payload_beat)
    );

    // header_seen also realigns the decoder to the hour field
    time_field_decoder time_field_decoder_i (
        .clk          (clk),
        .rst          (rst),
        .new_sentence (header_seen),
        .digit_beat   (payload_beat),
        .field_beat   (field_beat)
    );

    time_keeper time_keeper_i (
        .clk        (clk),
        .rst        (rst),
        .pps_in     (pps_in),
        .field_beat (field_beat),
        .time_now   (time_now),
        .time_valid (time_valid),
        .pps_tick   (pps_tick),
        .subsec     (subsec)
    );

endmodule

// File: tb/time_checker.sv
`timescale 1ns/1ns

module time_checker (
    input logic                   clk,
    input logic                   rst,
    input logic                   header_seen,
    input nmea_pkg::time_of_day_t time_now,
    input logic                   time_valid,
    input logic [31:0]            subsec,
    input logic                   pps_tick
);
    import nmea_pkg::*;

    int    header_count, tick_count, subsec_errors;  // Running totals since reset
    int    header_base, tick_base, subsec_base;      // Totals when the current test began
    int    passed, failed;
    string cur_name;
    logic  tick_d1, tick_d2;

    always @(posedge clk) begin
        if (rst) begin
            header_count  <= 0;
            tick_count    <= 0;
            subsec_errors <= 0;
            tick_d1       <= 1'b0;
            tick_d2       <= 1'b0;
        end else begin
            if (header_seen) header_count <= header_count + 1;
            if (pps_tick) tick_count <= tick_count + 1;
            tick_d1 <= pps_tick;
            tick_d2 <= tick_d1;
            // Sub-second count restarts at 0 right after the tick, then counts up
            if (tick_d1 && subsec != 32'd0) begin
                $display("mismatch %s subsec: expected 0, actual %0d", cur_name, subsec);
                subsec_errors <= subsec_errors + 1;
            end
            if (tick_d2 && subsec != 32'd1) begin
                $display("mismatch %s subsec: expected 1, actual %0d", cur_name, subsec);
                subsec_errors <= subsec_errors + 1;
            end
        end
    end

    task automatic begin_case(input string name);
        cur_name    = name;
        header_base = header_count;
        tick_base   = tick_count;
        subsec_base = subsec_errors;
    endtask

    task automatic check_case(input time_of_day_t exp_time, input logic exp_valid,
                              input int exp_headers, input int exp_ticks);
        int errors;
        errors = subsec_errors - subsec_base;
        if (header_count - header_base != exp_headers) begin
            $display("mismatch %s header_seen pulses: expected %0d, actual %0d",
                     cur_name, exp_headers, header_count - header_base);
            errors++;
        end
        if (tick_count - tick_base != exp_ticks) begin
            $display("mismatch %s pps_tick pulses: expected %0d, actual %0d",
                     cur_name, exp_ticks, tick_count - tick_base);
            errors++;
        end
        if (time_valid !== exp_valid) begin
            $display("mismatch %s time_valid: expected %0b, actual %0b",
                     cur_name, exp_valid, time_valid);
            errors++;
        end
        // The time of day only has a defined value once a sentence has loaded it
        if (exp_valid && time_now !== exp_time) begin
            $display("mismatch %s time_now: expected %02d:%02d:%02d, actual %02d:%02d:%02d",
                     cur_name, exp_time.hour, exp_time.minute, exp_time.second,
                     time_now.hour, time_now.minute, time_now.second);
            errors++;
        end
        if (header_seen || pps_tick) begin
            $display("ERROR %s: a pulse output is still high on an idle line", cur_name);
            errors++;
        end
        if (errors == 0) begin
            passed++;
            $display("PASS %s", cur_name);
        end else begin
            failed++;
            $display("FAIL %s with %0d errors", cur_name, errors);
        end
    endtask

    task automatic report_counts(input int timeouts, output int fail_count);
        $display("%0d tests passed, %0d failed, %0d timeouts", passed, failed, timeouts);
        fail_count = failed;
    endtask

endmodule

// File: tb/tb_gnss_time.sv
`timescale 1ns/1ns
`include "nmea_defs.svh"

module tb_gnss_time;
    import nmea_pkg::*;

    logic         clk;
    logic         rst;
    logic         uart_rx_line;
    logic         pps_in;
    logic         header_seen;
    time_of_day_t time_now;
    logic         time_valid;
    logic [31:0]  subsec;
    logic         pps_tick;

    int timeouts;
    int fails;
    int ran;
    int fd;
    logic loaded;  // Set once a ZDA sentence has been sent

    gnss_time_top gnss_time_top_i (
        .clk          (clk),
        .rst          (rst),
        .uart_rx_line (uart_rx_line),
        .pps_in       (pps_in),
        .header_seen  (header_seen),
        .time_now     (time_now),
        .time_valid   (time_valid),
        .subsec       (subsec),
        .pps_tick     (pps_tick)
    );

    time_checker checker_i (
        .clk         (clk),
        .rst         (rst),
        .header_seen (header_seen),
        .time_now    (time_now),
        .time_valid  (time_valid),
        .subsec      (subsec),
        .pps_tick    (pps_tick)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // 8N1 frame, LSB first, each bit held for one bit period
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            repeat (`NMEA_CLKS_PER_BIT) begin
                @(posedge clk);
                uart_rx_line <= frame[i];
            end
        end
    endtask

    task automatic send_sentence(input string hdr, input int hh, input int mm, input int ss);
        string s;
        s = $sformatf("$%s%02d%02d%02d.00,,,,,*00\r\n", hdr, hh, mm, ss);
        for (int i = 0; i < s.len(); i++) begin
            send_byte(s[i]);
        end
    endtask

    task automatic wait_time_valid(input string name);
        int n;
        n = 0;
        while (!time_valid && n < 2000) begin
            @(posedge clk);
            n++;
        end
        if (!time_valid) begin
            $display("ERROR %s: time_valid never rose after the sentence", name);
            timeouts++;
        end
    endtask

    // Full PPS pulse, held high until the tick shows up
    task automatic pps_pulse(input string name);
        int n;
        @(posedge clk);
        pps_in <= 1'b1;
        n = 0;
        while (!pps_tick && n < 40) begin
            @(posedge clk);
            n++;
        end
        if (!pps_tick) begin
            $display("ERROR %s: no pps_tick after a PPS rising edge", name);
            timeouts++;
        end
        repeat (4) @(posedge clk);
        pps_in <= 1'b0;
        repeat (40) @(posedge clk);  // Let the filtered level fall again
    endtask

    // High for fewer cycles than the debounce window
    task automatic pps_glitch();
        @(posedge clk);
        pps_in <= 1'b1;
        repeat (`NMEA_PPS_DEBOUNCE - 1) @(posedge clk);
        pps_in <= 1'b0;
        repeat (30) @(posedge clk);
    endtask

    initial begin
        string line;
        string name;
        string kind;
        int hh, mm, ss, pps, eh, em, es;
        time_of_day_t exp_time;
        rst          <= 1'b1;
        uart_rx_line <= 1'b1;
        pps_in       <= 1'b0;
        timeouts = 0;
        ran      = 0;
        loaded   = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("tb/timestamp_cases.txt", "r");
        if (fd == 0) $display("ERROR could not open tb/timestamp_cases.txt");
        while (fd != 0 && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;  // Comments and blank lines
            if ($sscanf(line, "%s %s %d %d %d %d %d %d %d", name, kind,
                        hh, mm, ss, pps, eh, em, es) != 9) continue;
            checker_i.begin_case(name);
            if (kind == "zda") send_sentence(`NMEA_HEADER, hh, mm, ss);
            else if (kind == "rmc") send_sentence("GPRMC,", hh, mm, ss);
            else if (kind == "glitch") repeat (pps) pps_glitch();
            else repeat (300) @(posedge clk);
            if (kind == "zda") begin
                loaded = 1'b1;
                wait_time_valid(name);
            end
            if (kind != "glitch") repeat (pps) pps_pulse(name);
            repeat (20) @(posedge clk);
            exp_time.hour   = 5'(eh);
            exp_time.minute = 6'(em);
            exp_time.second = 6'(es);
            @(negedge clk);  // Outputs are settled half a cycle after the edge
            checker_i.check_case(exp_time, loaded, (kind == "zda") ? 1 : 0,
                                 (kind == "glitch") ? 0 : pps);
            ran++;
        end
        checker_i.report_counts(timeouts, fails);
        if (fd != 0 && ran > 0 && fails == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
logic/uart_pkg.sv
logic/nmea_pkg.sv
logic/uart_rx.sv
logic/zda_search.sv
logic/time_field_decoder.sv
logic/time_keeper.sv
logic/gnss_time_top.sv
tb/time_checker.sv
tb/tb_gnss_time.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_gnss_time \
    -o sim_gnss_time

out=$(./obj_dir/sim_gnss_time)
echo "$out"

# The run passes only if the testbench printed the pass message
echo "$out" | grep -q -F '*** PASSED ***'

// File: tb/timestamp_cases.txt
# name kind hh mm ss pps exp_hh exp_mm exp_ss
# kind is zda or rmc for a sentence, idle for a quiet line, glitch for short PPS pulses
reset_idle   idle   00 00 00 0 00 00 00
load_noon    zda    12 34 56 0 12 34 56
tick_three   zda    12 34 56 3 12 34 59
day_wrap     zda    23 59 59 1 00 00 00
minute_wrap  zda    10 14 58 2 10 15 00
hour_wrap    zda    07 59 59 1 08 00 00
other_header rmc    05 05 05 0 08 00 00
rmc_ticks    rmc    01 02 03 2 08 00 02
pps_glitch   glitch 00 00 00 2 08 00 02
half_minute  zda    18 30 29 1 18 30 30
